/* bench/mips_trace.txt */
# L <instruction memory index, hex> <instruction word, hex>
# E <register number, hex> <expected value after halt, hex>
L 00 20010035  addi r1, r0, 0x35
L 01 2022fffa  addi r2, r1, -6
L 02 00221821  addu r3, r1, r2
L 03 00432023  subu r4, r2, r3
L 04 00832824  and  r5, r4, r3
L 05 00a13025  or   r6, r5, r1
L 06 0085382a  slt  r7, r4, r5
L 07 3c081234  lui  r8, 0x1234
L 08 01064825  or   r9, r8, r6
L 09 00a4502a  slt  r10, r5, r4
L 0a ac090010  sw   r9, 16(r0)
L 0b 8c0b0010  lw   r11, 16(r0)
L 0c 01616021  addu r12, r11, r1
L 0d 10210003  beq  r1, r1, +3
L 0e 200107ff  addi r1, r0, 0x7ff
L 0f 20060001  addi r6, r0, 1
L 10 200c0002  addi r12, r0, 2
L 11 14630002  bne  r3, r3, +2
L 12 218d0001  addi r13, r12, 1
L 13 01ac7023  subu r14, r13, r12
L 14 fc000000  halt
L 15 20010bad  addi r1, r0, 0xbad
E 00 00000000
E 01 00000035
E 02 0000002f
E 03 00000064
E 04 ffffffcb
E 05 00000040
E 06 00000075
E 07 00000001
E 08 12340000
E 09 12340075
E 0a 00000000
E 0b 12340075
E 0c 123400aa
E 0d 123400ab
E 0e 00000001

/* bench/tb_mips.sv */
`timescale 1ns/1ps

module tb_mips import mips_pkg::*; ();

    localparam int IMEM_DEPTH   = 256;
    localparam int DMEM_DEPTH   = 1024;
    localparam int ADDR_BITS    = $clog2(IMEM_DEPTH);
    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 10;
    localparam int ACK_TIMEOUT  = 20;
    localparam int HALT_TIMEOUT = 500;
    localparam int HOLD_CYCLES  = 8;

    logic                     clk;
    logic                     reset;
    logic                     enable;
    logic                     load_req;
    logic [ADDR_BITS-1:0]     load_addr;
    logic [WORD_BITS-1:0]     load_data;
    logic [REG_ADDR_BITS-1:0] debug_reg_addr;
    logic                     load_ack;
    logic [WORD_BITS-1:0]     pc;
    logic [WORD_BITS-1:0]     reg_data;
    logic                     mips_halt;

    logic [ADDR_BITS-1:0]     prog_addr[$];
    logic [WORD_BITS-1:0]     prog_word[$];
    logic [REG_ADDR_BITS-1:0] exp_reg[$];
    logic [WORD_BITS-1:0]     exp_val[$];

    int mismatches;
    int failures;
    bit stop_run;

    mips_top #(
        .IMEM_DEPTH       (IMEM_DEPTH),
        .DMEM_DEPTH       (DMEM_DEPTH)
    ) u_dut (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_enable         (enable),
        .i_load_req       (load_req),
        .i_load_addr      (load_addr),
        .i_load_data      (load_data),
        .i_debug_reg_addr (debug_reg_addr),
        .o_load_ack       (load_ack),
        .o_pc             (pc),
        .o_data_reg_file  (reg_data),
        .o_mips_halt      (mips_halt)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Program words and expected registers from the trace
    task automatic read_trace();
        int fd;
        int code;
        string line;
        byte kind;
        logic [31:0] field_a;
        logic [31:0] field_b;
        fd = $fopen("bench/mips_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/mips_trace.txt");
            failures++;
            stop_run = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) != "#") begin
                code = $sscanf(line, "%c %h %h", kind, field_a, field_b);
                if (code == 3 && kind == "L") begin
                    prog_addr.push_back(field_a[ADDR_BITS-1:0]);
                    prog_word.push_back(field_b);
                end else if (code == 3 && kind == "E") begin
                    exp_reg.push_back(field_a[REG_ADDR_BITS-1:0]);
                    exp_val.push_back(field_b);
                end
            end
        end
        $fclose(fd);
        if (prog_word.size() == 0 || exp_val.size() == 0) begin
            $display("The trace holds no program words or no expected registers");
            failures++;
            stop_run = 1'b1;
        end
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (load_ack !== level && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (load_ack !== level) begin
            $display("Timeout at %0t ns: o_load_ack did not go to %0d within %0d cycles",
                     $time, level, ACK_TIMEOUT);
            failures++;
            stop_run = 1'b1;
        end
    endtask

    // One four-phase transfer into the instruction memory
    task automatic load_word(input logic [ADDR_BITS-1:0] addr,
                             input logic [WORD_BITS-1:0] word);
        @(posedge clk);
        load_req  <= 1'b1;
        load_addr <= addr;
        load_data <= word;
        // Request not yet sampled by the DUT
        @(negedge clk);
        assert (load_ack === 1'b0) else begin
            $display("[ERROR] %0t ns: o_load_ack got %b expected 0 before request sampled",
                     $time, load_ack);
            mismatches++;
        end
        wait_ack(1'b1);
        if (stop_run) begin
            return;
        end
        @(posedge clk);
        load_req <= 1'b0;
        // Ack stays up until the dropped request is sampled
        @(negedge clk);
        assert (load_ack === 1'b1) else begin
            $display("[ERROR] %0t ns: o_load_ack got %b expected 1 after request drop",
                     $time, load_ack);
            mismatches++;
        end
        wait_ack(1'b0);
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (mips_halt !== 1'b1 && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (mips_halt !== 1'b1) begin
            $display("Timeout at %0t ns: the core did not halt within %0d cycles",
                     $time, HALT_TIMEOUT);
            failures++;
            stop_run = 1'b1;
        end
    endtask

    // Halt is sticky and the PC stays frozen
    task automatic check_halt_hold();
        logic [WORD_BITS-1:0] pc_at_halt;
        pc_at_halt = pc;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            assert (mips_halt === 1'b1) else begin
                $display("[ERROR] %0t ns: o_mips_halt got %b expected 1", $time, mips_halt);
                mismatches++;
            end
            assert (pc === pc_at_halt) else begin
                $display("[ERROR] %0t ns: o_pc got %h expected %h", $time, pc, pc_at_halt);
                mismatches++;
            end
        end
    endtask

    task automatic check_regs();
        for (int i = 0; i < exp_reg.size(); i++) begin
            @(posedge clk);
            debug_reg_addr <= exp_reg[i];
            @(negedge clk);
            assert (reg_data === exp_val[i]) else begin
                $display("[ERROR] %0t ns: o_data_reg_file[r%0d] got %h expected %h",
                         $time, exp_reg[i], reg_data, exp_val[i]);
                mismatches++;
            end
        end
    endtask

    task automatic run_program();
        if (stop_run) begin
            return;
        end
        for (int i = 0; i < prog_word.size() && !stop_run; i++) begin
            load_word(prog_addr[i], prog_word[i]);
        end
        if (stop_run) begin
            return;
        end
        @(posedge clk);
        enable <= 1'b1;
        wait_halt();
        if (stop_run) begin
            return;
        end
        check_halt_hold();
        check_regs();
    endtask

    initial begin
        reset          = 1'b1;
        enable         = 1'b0;
        load_req       = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        debug_reg_addr = '0;
        mismatches     = 0;
        failures       = 0;
        stop_run       = 1'b0;

        read_trace();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (load_ack === 1'b0) else begin
            $display("[ERROR] %0t ns: o_load_ack got %b expected 0 after reset",
                     $time, load_ack);
            mismatches++;
        end

        run_program();

        $display("Run finished: %0d value mismatches, %0d other failures",
                 mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* common/mips_pkg.sv */
package mips_pkg;

    localparam int WORD_BITS     = 32;
    localparam int REG_ADDR_BITS = 5;
    localparam int OPCODE_BITS   = 6;
    localparam int FUNCT_BITS    = 6;
    localparam int IMM_BITS      = 16;

    localparam logic [OPCODE_BITS-1:0] OP_RTYPE = 6'h00;
    localparam logic [OPCODE_BITS-1:0] OP_ADDI  = 6'h08;
    localparam logic [OPCODE_BITS-1:0] OP_LUI   = 6'h0f;
    localparam logic [OPCODE_BITS-1:0] OP_LW    = 6'h23;
    localparam logic [OPCODE_BITS-1:0] OP_SW    = 6'h2b;
    localparam logic [OPCODE_BITS-1:0] OP_BEQ   = 6'h04;
    localparam logic [OPCODE_BITS-1:0] OP_BNE   = 6'h05;
    localparam logic [OPCODE_BITS-1:0] OP_HALT  = 6'h3f;

    localparam logic [FUNCT_BITS-1:0] FN_ADDU = 6'h21;
    localparam logic [FUNCT_BITS-1:0] FN_SUBU = 6'h23;
    localparam logic [FUNCT_BITS-1:0] FN_AND  = 6'h24;
    localparam logic [FUNCT_BITS-1:0] FN_OR   = 6'h25;
    localparam logic [FUNCT_BITS-1:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_t;

    // One instruction word, R-type or I-type layout
    typedef union packed {
        struct packed {
            logic [OPCODE_BITS-1:0]   opcode;
            logic [REG_ADDR_BITS-1:0] rs;
            logic [REG_ADDR_BITS-1:0] rt;
            logic [REG_ADDR_BITS-1:0] rd;
            logic [REG_ADDR_BITS-1:0] shamt;
            logic [FUNCT_BITS-1:0]    funct;
        } r_fields;
        struct packed {
            logic [OPCODE_BITS-1:0]   opcode;
            logic [REG_ADDR_BITS-1:0] rs;
            logic [REG_ADDR_BITS-1:0] rt;
            logic [IMM_BITS-1:0]      imm;
        } i_fields;
    } instr_t;

endpackage

/* decode/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_enable,
    input  logic [WORD_BITS-1:0]     i_if_id_pc4,
    input  logic [WORD_BITS-1:0]     i_if_id_instr,
    input  logic                     i_flush,
    input  logic                     i_wb_write,
    input  logic [REG_ADDR_BITS-1:0] i_wb_dest,
    input  logic [WORD_BITS-1:0]     i_wb_data,
    input  logic [REG_ADDR_BITS-1:0] i_debug_reg_addr,
    output logic                     o_pc_hold,
    output logic [WORD_BITS-1:0]     o_debug_reg_data,
    output logic [WORD_BITS-1:0]     o_id_ex_pc4,
    output logic [WORD_BITS-1:0]     o_id_ex_instr,
    output logic [WORD_BITS-1:0]     o_id_ex_rs_data,
    output logic [WORD_BITS-1:0]     o_id_ex_rt_data,
    output logic [WORD_BITS-1:0]     o_id_ex_imm,
    output logic [REG_ADDR_BITS-1:0] o_id_ex_dest,
    output logic                     o_id_ex_reg_write,
    output logic                     o_id_ex_mem_read,
    output logic                     o_id_ex_mem_write,
    output logic                     o_id_ex_mem_to_reg,
    output logic                     o_id_ex_alu_src,
    output logic                     o_id_ex_branch,
    output logic                     o_id_ex_branch_ne,
    output logic                     o_id_ex_halt
);

    instr_t id_instr;
    instr_t ex_instr;
    logic [WORD_BITS-1:0] regs [2**REG_ADDR_BITS];
    logic [WORD_BITS-1:0] rs_data, rt_data;
    logic [REG_ADDR_BITS-1:0] rs, rt, dest;
    logic is_rtype, reg_write, mem_read, mem_write, mem_to_reg, alu_src;
    logic branch, branch_ne, is_halt;
    logic load_use, halted, kill;

    assign id_instr = i_if_id_instr;
    assign ex_instr = o_id_ex_instr;
    assign rs       = id_instr.r_fields.rs;
    assign rt       = id_instr.r_fields.rt;
    assign dest     = is_rtype ? id_instr.r_fields.rd : id_instr.i_fields.rt;

    always_comb begin
        is_rtype   = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        alu_src    = 1'b0;
        branch     = 1'b0;
        branch_ne  = 1'b0;
        is_halt    = 1'b0;
        case (id_instr.i_fields.opcode)
            OP_RTYPE: begin
                is_rtype  = 1'b1;
                reg_write = 1'b1;
            end
            OP_ADDI, OP_LUI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OP_LW: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                alu_src    = 1'b1;
            end
            OP_SW: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
            end
            OP_BEQ: branch = 1'b1;
            OP_BNE: begin
                branch    = 1'b1;
                branch_ne = 1'b1;
            end
            OP_HALT: is_halt = 1'b1;
            default: is_rtype = 1'b0;
        endcase
    end

    // Write-first read, register 0 is hardwired
    function automatic logic [WORD_BITS-1:0] read_reg(input logic [REG_ADDR_BITS-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wb_write && i_wb_dest == addr) begin
            return i_wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data          = read_reg(rs);
        rt_data          = read_reg(rt);
        o_debug_reg_data = read_reg(i_debug_reg_addr);
    end

    always_ff @(posedge i_clk) begin
        if (i_wb_write && i_wb_dest != '0) begin
            regs[i_wb_dest] <= i_wb_data;
        end
    end

    // Load in EX feeding this instruction
    assign load_use  = o_id_ex_mem_read && (ex_instr.i_fields.rt == rs || ex_instr.i_fields.rt == rt);
    assign o_pc_hold = load_use || is_halt || halted;
    assign kill      = i_flush || load_use || halted;

    // HALT passes once, everything after it is a bubble
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            halted <= 1'b0;
        end else if (i_enable) begin
            halted <= !i_flush && (halted || (is_halt && !load_use));
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_id_ex_reg_write  <= 1'b0;
            o_id_ex_mem_read   <= 1'b0;
            o_id_ex_mem_write  <= 1'b0;
            o_id_ex_mem_to_reg <= 1'b0;
            o_id_ex_alu_src    <= 1'b0;
            o_id_ex_branch     <= 1'b0;
            o_id_ex_branch_ne  <= 1'b0;
            o_id_ex_halt       <= 1'b0;
        end else if (i_enable) begin
            o_id_ex_reg_write  <= reg_write && !kill;
            o_id_ex_mem_read   <= mem_read && !kill;
            o_id_ex_mem_write  <= mem_write && !kill;
            o_id_ex_mem_to_reg <= mem_to_reg && !kill;
            o_id_ex_alu_src    <= alu_src && !kill;
            o_id_ex_branch     <= branch && !kill;
            o_id_ex_branch_ne  <= branch_ne && !kill;
            o_id_ex_halt       <= is_halt && !kill;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_enable) begin
            o_id_ex_pc4     <= i_if_id_pc4;
            o_id_ex_instr   <= i_if_id_instr;
            o_id_ex_rs_data <= rs_data;
            o_id_ex_rt_data <= rt_data;
            o_id_ex_imm     <= {{(WORD_BITS-IMM_BITS){id_instr.i_fields.imm[IMM_BITS-1]}},
                                id_instr.i_fields.imm};
            o_id_ex_dest    <= dest;
        end
    end

    // A write-back aimed at register 0 must not reach the bypass
    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_enable && i_wb_write && i_wb_dest == '0 && rs == '0) |=> o_id_ex_rs_data == '0);

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_enable,
    input  logic                     i_flush,
    input  logic [WORD_BITS-1:0]     i_id_ex_pc4,
    input  logic [WORD_BITS-1:0]     i_id_ex_instr,
    input  logic [WORD_BITS-1:0]     i_id_ex_rs_data,
    input  logic [WORD_BITS-1:0]     i_id_ex_rt_data,
    input  logic [WORD_BITS-1:0]     i_id_ex_imm,
    input  logic [REG_ADDR_BITS-1:0] i_id_ex_dest,
    input  logic                     i_id_ex_reg_write,
    input  logic                     i_id_ex_mem_read,
    input  logic                     i_id_ex_mem_write,
    input  logic                     i_id_ex_mem_to_reg,
    input  logic                     i_id_ex_alu_src,
    input  logic                     i_id_ex_branch,
    input  logic                     i_id_ex_branch_ne,
    input  logic                     i_id_ex_halt,
    input  logic                     i_wb_write,
    input  logic [REG_ADDR_BITS-1:0] i_wb_dest,
    input  logic [WORD_BITS-1:0]     i_wb_data,
    output logic [WORD_BITS-1:0]     o_ex_mem_result,
    output logic                     o_ex_mem_zero,
    output logic [WORD_BITS-1:0]     o_ex_mem_store_data,
    output logic [REG_ADDR_BITS-1:0] o_ex_mem_dest,
    output logic [WORD_BITS-1:0]     o_ex_mem_branch_target,
    output logic                     o_ex_mem_reg_write,
    output logic                     o_ex_mem_mem_read,
    output logic                     o_ex_mem_mem_write,
    output logic                     o_ex_mem_mem_to_reg,
    output logic                     o_ex_mem_branch,
    output logic                     o_ex_mem_branch_ne,
    output logic                     o_ex_mem_halt
);

    instr_t ex_instr;
    alu_op_t alu_op;
    fwd_sel_t fwd_a, fwd_b;
    logic [WORD_BITS-1:0] op_a, rt_fwd, op_b, alu_result;

    assign ex_instr = i_id_ex_instr;

    always_comb begin
        case (ex_instr.r_fields.opcode)
            OP_RTYPE: begin
                case (ex_instr.r_fields.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_LUI:         alu_op = ALU_LUI;
            OP_BEQ, OP_BNE: alu_op = ALU_SUB;
            default:        alu_op = ALU_ADD;
        endcase
    end

    // Youngest producer first, register 0 never forwarded
    function automatic fwd_sel_t pick_fwd(input logic [REG_ADDR_BITS-1:0] src);
        if (src == '0) begin
            return FWD_NONE;
        end else if (o_ex_mem_reg_write && o_ex_mem_dest == src) begin
            return FWD_EXMEM;
        end else if (i_wb_write && i_wb_dest == src) begin
            return FWD_MEMWB;
        end
        return FWD_NONE;
    endfunction

    function automatic logic [WORD_BITS-1:0] fwd_mux(input fwd_sel_t sel,
                                                     input logic [WORD_BITS-1:0] reg_data);
        case (sel)
            FWD_EXMEM: return o_ex_mem_result;
            FWD_MEMWB: return i_wb_data;
            default:   return reg_data;
        endcase
    endfunction

    always_comb begin
        fwd_a  = pick_fwd(ex_instr.r_fields.rs);
        fwd_b  = pick_fwd(ex_instr.r_fields.rt);
        op_a   = fwd_mux(fwd_a, i_id_ex_rs_data);
        rt_fwd = fwd_mux(fwd_b, i_id_ex_rt_data);
        op_b   = i_id_ex_alu_src ? i_id_ex_imm : rt_fwd;
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = WORD_BITS'($signed(op_a) < $signed(op_b));
            ALU_LUI: alu_result = {op_b[IMM_BITS-1:0], {(WORD_BITS-IMM_BITS){1'b0}}};
            default: alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ex_mem_reg_write  <= 1'b0;
            o_ex_mem_mem_read   <= 1'b0;
            o_ex_mem_mem_write  <= 1'b0;
            o_ex_mem_mem_to_reg <= 1'b0;
            o_ex_mem_branch     <= 1'b0;
            o_ex_mem_branch_ne  <= 1'b0;
            o_ex_mem_halt       <= 1'b0;
        end else if (i_enable) begin
            o_ex_mem_reg_write  <= i_id_ex_reg_write && !i_flush;
            o_ex_mem_mem_read   <= i_id_ex_mem_read && !i_flush;
            o_ex_mem_mem_write  <= i_id_ex_mem_write && !i_flush;
            o_ex_mem_mem_to_reg <= i_id_ex_mem_to_reg && !i_flush;
            o_ex_mem_branch     <= i_id_ex_branch && !i_flush;
            o_ex_mem_branch_ne  <= i_id_ex_branch_ne && !i_flush;
            o_ex_mem_halt       <= i_id_ex_halt && !i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_enable) begin
            o_ex_mem_result        <= alu_result;
            o_ex_mem_zero          <= (alu_result == '0);
            o_ex_mem_store_data    <= rt_fwd;
            o_ex_mem_dest          <= i_id_ex_dest;
            // Target is PC+4 plus the word offset
            o_ex_mem_branch_target <= i_id_ex_pc4 + {i_id_ex_imm[WORD_BITS-3:0], 2'b00};
        end
    end

endmodule

/* fetch/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_enable,
    input  logic                          i_load_req,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_load_addr,
    input  logic [WORD_BITS-1:0]          i_load_data,
    input  logic                          i_pc_hold,
    input  logic                          i_branch_taken,
    input  logic [WORD_BITS-1:0]          i_branch_target,
    output logic                          o_load_ack,
    output logic [WORD_BITS-1:0]          o_pc,
    output logic [WORD_BITS-1:0]          o_if_id_pc4,
    output logic [WORD_BITS-1:0]          o_if_id_instr
);

    localparam int IMEM_ADDR_BITS = $clog2(IMEM_DEPTH);

    logic [WORD_BITS-1:0] imem [IMEM_DEPTH];
    logic [WORD_BITS-1:0] pc4;
    logic [WORD_BITS-1:0] fetched;

    assign pc4     = o_pc + WORD_BITS'(4);
    assign fetched = imem[o_pc[IMEM_ADDR_BITS+1:2]];

    // Four-phase load, word written on the edge ack rises
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_load_ack <= 1'b0;
        end else if (i_load_req && !o_load_ack) begin
            o_load_ack <= 1'b1;
        end else if (!i_load_req) begin
            o_load_ack <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load_req && !o_load_ack) begin
            imem[i_load_addr] <= i_load_data;
        end
    end

    // Taken branch wins over hold and turns IF/ID into a nop
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc          <= '0;
            o_if_id_pc4   <= '0;
            o_if_id_instr <= '0;
        end else if (i_enable) begin
            if (i_branch_taken) begin
                o_pc          <= i_branch_target;
                o_if_id_pc4   <= '0;
                o_if_id_instr <= '0;
            end else if (!i_pc_hold) begin
                o_pc          <= pc4;
                o_if_id_pc4   <= pc4;
                o_if_id_instr <= fetched;
            end
        end
    end

    // Program is loaded only while the core is stopped
    assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_load_req && i_enable));

    assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_load_ack) |-> $past(i_load_req));

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_mips -f vlog.f -o tb_mips \
    && ./obj_dir/tb_mips | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; #(
    parameter int DMEM_DEPTH = 1024
) (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_enable,
    input  logic [WORD_BITS-1:0]     i_ex_mem_result,
    input  logic                     i_ex_mem_zero,
    input  logic [WORD_BITS-1:0]     i_ex_mem_store_data,
    input  logic [REG_ADDR_BITS-1:0] i_ex_mem_dest,
    input  logic [WORD_BITS-1:0]     i_ex_mem_branch_target,
    input  logic                     i_ex_mem_reg_write,
    input  logic                     i_ex_mem_mem_read,
    input  logic                     i_ex_mem_mem_write,
    input  logic                     i_ex_mem_mem_to_reg,
    input  logic                     i_ex_mem_branch,
    input  logic                     i_ex_mem_branch_ne,
    input  logic                     i_ex_mem_halt,
    output logic                     o_branch_taken,
    output logic [WORD_BITS-1:0]     o_branch_target,
    output logic                     o_wb_write,
    output logic [REG_ADDR_BITS-1:0] o_wb_dest,
    output logic [WORD_BITS-1:0]     o_wb_data,
    output logic                     o_mips_halt
);

    localparam int DMEM_ADDR_BITS = $clog2(DMEM_DEPTH);

    logic [WORD_BITS-1:0] dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_BITS-1:0] word_addr;
    logic [WORD_BITS-1:0] load_data;

    assign word_addr = i_ex_mem_result[DMEM_ADDR_BITS+1:2];
    assign load_data = i_ex_mem_mem_read ? dmem[word_addr] : '0;

    // BEQ on zero, BNE on non-zero
    assign o_branch_taken  = i_ex_mem_branch && (i_ex_mem_zero != i_ex_mem_branch_ne);
    assign o_branch_target = i_ex_mem_branch_target;

    always_ff @(posedge i_clk) begin
        if (i_enable && i_ex_mem_mem_write) begin
            dmem[word_addr] <= i_ex_mem_store_data;
        end
    end

    // MEM/WB, halt is sticky until reset
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_write  <= 1'b0;
            o_mips_halt <= 1'b0;
        end else if (i_enable) begin
            o_wb_write  <= i_ex_mem_reg_write;
            o_mips_halt <= o_mips_halt || i_ex_mem_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_enable) begin
            o_wb_dest <= i_ex_mem_dest;
            o_wb_data <= i_ex_mem_mem_to_reg ? load_data : i_ex_mem_result;
        end
    end

endmodule

/* source/mips_top.sv */
`timescale 1ns/1ps

module mips_top import mips_pkg::*; #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 1024
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_enable,
    input  logic                          i_load_req,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_load_addr,
    input  logic [WORD_BITS-1:0]          i_load_data,
    input  logic [REG_ADDR_BITS-1:0]      i_debug_reg_addr,
    output logic                          o_load_ack,
    output logic [WORD_BITS-1:0]          o_pc,
    output logic [WORD_BITS-1:0]          o_data_reg_file,
    output logic                          o_mips_halt
);

    logic [WORD_BITS-1:0] if_id_pc4, if_id_instr, branch_target;
    logic pc_hold, branch_taken;

    logic [WORD_BITS-1:0] id_ex_pc4, id_ex_instr, id_ex_rs_data, id_ex_rt_data, id_ex_imm;
    logic [REG_ADDR_BITS-1:0] id_ex_dest;
    logic id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_mem_to_reg;
    logic id_ex_alu_src, id_ex_branch, id_ex_branch_ne, id_ex_halt;

    logic [WORD_BITS-1:0] ex_mem_result, ex_mem_store_data, ex_mem_branch_target;
    logic [REG_ADDR_BITS-1:0] ex_mem_dest;
    logic ex_mem_zero, ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write;
    logic ex_mem_mem_to_reg, ex_mem_branch, ex_mem_branch_ne, ex_mem_halt;

    logic [WORD_BITS-1:0] wb_data;
    logic [REG_ADDR_BITS-1:0] wb_dest;
    logic wb_write;

    fetch_stage #(
        .IMEM_DEPTH         (IMEM_DEPTH)
    ) u_fetch (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_enable           (i_enable),
        .i_load_req         (i_load_req),
        .i_load_addr        (i_load_addr),
        .i_load_data        (i_load_data),
        .i_pc_hold          (pc_hold),
        .i_branch_taken     (branch_taken),
        .i_branch_target    (branch_target),
        .o_load_ack         (o_load_ack),
        .o_pc               (o_pc),
        .o_if_id_pc4        (if_id_pc4),
        .o_if_id_instr      (if_id_instr)
    );

    decode_stage u_decode (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_enable           (i_enable),
        .i_if_id_pc4        (if_id_pc4),
        .i_if_id_instr      (if_id_instr),
        .i_flush            (branch_taken),
        .i_wb_write         (wb_write),
        .i_wb_dest          (wb_dest),
        .i_wb_data          (wb_data),
        .i_debug_reg_addr   (i_debug_reg_addr),
        .o_pc_hold          (pc_hold),
        .o_debug_reg_data   (o_data_reg_file),
        .o_id_ex_pc4        (id_ex_pc4),
        .o_id_ex_instr      (id_ex_instr),
        .o_id_ex_rs_data    (id_ex_rs_data),
        .o_id_ex_rt_data    (id_ex_rt_data),
        .o_id_ex_imm        (id_ex_imm),
        .o_id_ex_dest       (id_ex_dest),
        .o_id_ex_reg_write  (id_ex_reg_write),
        .o_id_ex_mem_read   (id_ex_mem_read),
        .o_id_ex_mem_write  (id_ex_mem_write),
        .o_id_ex_mem_to_reg (id_ex_mem_to_reg),
        .o_id_ex_alu_src    (id_ex_alu_src),
        .o_id_ex_branch     (id_ex_branch),
        .o_id_ex_branch_ne  (id_ex_branch_ne),
        .o_id_ex_halt       (id_ex_halt)
    );

    execute_stage u_execute (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_enable               (i_enable),
        .i_flush                (branch_taken),
        .i_id_ex_pc4            (id_ex_pc4),
        .i_id_ex_instr          (id_ex_instr),
        .i_id_ex_rs_data        (id_ex_rs_data),
        .i_id_ex_rt_data        (id_ex_rt_data),
        .i_id_ex_imm            (id_ex_imm),
        .i_id_ex_dest           (id_ex_dest),
        .i_id_ex_reg_write      (id_ex_reg_write),
        .i_id_ex_mem_read       (id_ex_mem_read),
        .i_id_ex_mem_write      (id_ex_mem_write),
        .i_id_ex_mem_to_reg     (id_ex_mem_to_reg),
        .i_id_ex_alu_src        (id_ex_alu_src),
        .i_id_ex_branch         (id_ex_branch),
        .i_id_ex_branch_ne      (id_ex_branch_ne),
        .i_id_ex_halt           (id_ex_halt),
        .i_wb_write             (wb_write),
        .i_wb_dest              (wb_dest),
        .i_wb_data              (wb_data),
        .o_ex_mem_result        (ex_mem_result),
        .o_ex_mem_zero          (ex_mem_zero),
        .o_ex_mem_store_data    (ex_mem_store_data),
        .o_ex_mem_dest          (ex_mem_dest),
        .o_ex_mem_branch_target (ex_mem_branch_target),
        .o_ex_mem_reg_write     (ex_mem_reg_write),
        .o_ex_mem_mem_read      (ex_mem_mem_read),
        .o_ex_mem_mem_write     (ex_mem_mem_write),
        .o_ex_mem_mem_to_reg    (ex_mem_mem_to_reg),
        .o_ex_mem_branch        (ex_mem_branch),
        .o_ex_mem_branch_ne     (ex_mem_branch_ne),
        .o_ex_mem_halt          (ex_mem_halt)
    );

    memory_stage #(
        .DMEM_DEPTH             (DMEM_DEPTH)
    ) u_memory (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_enable               (i_enable),
        .i_ex_mem_result        (ex_mem_result),
        .i_ex_mem_zero          (ex_mem_zero),
        .i_ex_mem_store_data    (ex_mem_store_data),
        .i_ex_mem_dest          (ex_mem_dest),
        .i_ex_mem_branch_target (ex_mem_branch_target),
        .i_ex_mem_reg_write     (ex_mem_reg_write),
        .i_ex_mem_mem_read      (ex_mem_mem_read),
        .i_ex_mem_mem_write     (ex_mem_mem_write),
        .i_ex_mem_mem_to_reg    (ex_mem_mem_to_reg),
        .i_ex_mem_branch        (ex_mem_branch),
        .i_ex_mem_branch_ne     (ex_mem_branch_ne),
        .i_ex_mem_halt          (ex_mem_halt),
        .o_branch_taken         (branch_taken),
        .o_branch_target        (branch_target),
        .o_wb_write             (wb_write),
        .o_wb_dest              (wb_dest),
        .o_wb_data              (wb_data),
        .o_mips_halt            (o_mips_halt)
    );

endmodule

/* vlog.f */
common/mips_pkg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
source/memory_stage.sv
source/mips_top.sv
bench/tb_mips.sv
